/* Bender.yml */
package:
  name: lpf_channel

sources:
  - logic/audFiltPkg.sv
  - logic/coefRegs.sv
  - logic/biquadSection.sv
  - logic/powerMeter.sv
  - logic/lpfChannel.sv
  - target: simulation
    files:
      - tb/lpfChannelTb.sv

/* logic/audFiltPkg.sv */
package audFiltPkg;

	// Sample and coefficient words
	typedef logic signed [15:0] audIn_t;     // Raw signed audio input
	typedef logic signed [26:0] audSample_t; // Q4.23 sample inside the channel
	typedef logic signed [26:0] coef_t;      // Q4.23 coefficient, 1.0 at bit 23

	// Power measurement
	typedef logic [10:0] power_t;
	typedef logic [39:0] powerAcc_t;

	// APB bus words
	typedef logic [7:0]  apbAddr_t;
	typedef logic [31:0] apbData_t;

	// Filter arithmetic
	localparam int COEF_FRAC = 23;        // Fraction bits and product sum shift
	localparam int BQ_SUM_W  = 57;        // Five 54-bit products plus carry growth
	localparam coef_t COEF_ONE = 27'sh0800000;

	// Coefficient layout in the register block
	localparam int NUM_COEF         = 10;
	localparam int COEF_PER_SECTION = 5;  // b0, b1, b2, a1, a2

	// Power window
	localparam int WINDOW_LEN = 9600;
	localparam int WIN_CNT_W  = $clog2(WINDOW_LEN);
	localparam int POWER_LSB  = 26;       // Lowest accumulator bit in the reading

	// Register map, byte addresses
	localparam apbAddr_t ADDR_CTRL      = 8'h00; // Bit 0 is the channel enable
	localparam apbAddr_t ADDR_COEF_BASE = 8'h04;
	localparam apbAddr_t ADDR_POWER     = 8'h2C; // Read only

	// Section 0 occupies 0x04 to 0x14 and section 1 follows at 0x18 to 0x28.
	// Within a section the order is b0, b1, b2, a1, a2.
	// The a0 term is fixed at 1.0 and has no register.

	// Any address above ADDR_POWER or off a word boundary is an error.
	// A write to ADDR_POWER is an error as well and changes nothing.

endpackage

/* logic/biquadSection.sv */
module biquadSection (
	input  logic                    aud_clk,
	input  logic                    reset,
	input  logic                    enable,

	input  logic                    inValid,
	input  audFiltPkg::audSample_t  inSample,

	input  audFiltPkg::coef_t       b0,
	input  audFiltPkg::coef_t       b1,
	input  audFiltPkg::coef_t       b2,
	input  audFiltPkg::coef_t       a1,
	input  audFiltPkg::coef_t       a2,

	output logic                    outValid,
	output audFiltPkg::audSample_t  outSample
);

	// Direct form I delay line
	audFiltPkg::audSample_t x1;
	audFiltPkg::audSample_t x2;
	audFiltPkg::audSample_t y1;
	audFiltPkg::audSample_t y2;

	logic signed [audFiltPkg::BQ_SUM_W-1:0] pB0;
	logic signed [audFiltPkg::BQ_SUM_W-1:0] pB1;
	logic signed [audFiltPkg::BQ_SUM_W-1:0] pB2;
	logic signed [audFiltPkg::BQ_SUM_W-1:0] pA1;
	logic signed [audFiltPkg::BQ_SUM_W-1:0] pA2;
	logic signed [audFiltPkg::BQ_SUM_W-1:0] acc;
	logic signed [audFiltPkg::BQ_SUM_W-1:0] accShift;
	audFiltPkg::audSample_t                 nextY;

	// Products are formed at the full sum width so no bits are lost before the shift
	always_comb begin
		pB0 = b0 * inSample;
		pB1 = b1 * x1;
		pB2 = b2 * x2;
		pA1 = a1 * y1;
		pA2 = a2 * y2;
		acc = pB0 + pB1 + pB2 - pA1 - pA2;
		accShift = acc >>> audFiltPkg::COEF_FRAC; // Back to Q4.23
		nextY = accShift[26:0];                   // Wraps on overflow
	end

	always_ff @(posedge aud_clk) begin
		if (reset || !enable) begin
			// Disabled means the section rests at zero
			outValid  <= 1'b0;
			outSample <= '0;
			x1 <= '0;
			x2 <= '0;
			y1 <= '0;
			y2 <= '0;
		end else begin
			outValid <= inValid;
			if (inValid) begin
				outSample <= nextY;
				x1 <= inSample;
				x2 <= x1;
				y1 <= nextY;
				y2 <= y1;
			end
		end
	end

endmodule

/* logic/coefRegs.sv */
module coefRegs (
	input  logic                  aud_clk,
	input  logic                  reset,

	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  audFiltPkg::apbAddr_t  paddr,
	input  audFiltPkg::apbData_t  pwdata,
	output audFiltPkg::apbData_t  prdata,
	output logic                  pready,
	output logic                  pslverr,

	input  audFiltPkg::power_t    power,

	output logic                  enable,
	output audFiltPkg::coef_t     s0B0,
	output audFiltPkg::coef_t     s0B1,
	output audFiltPkg::coef_t     s0B2,
	output audFiltPkg::coef_t     s0A1,
	output audFiltPkg::coef_t     s0A2,
	output audFiltPkg::coef_t     s1B0,
	output audFiltPkg::coef_t     s1B1,
	output audFiltPkg::coef_t     s1B2,
	output audFiltPkg::coef_t     s1A1,
	output audFiltPkg::coef_t     s1A2
);

	audFiltPkg::coef_t    coefMem [0:audFiltPkg::NUM_COEF-1];
	audFiltPkg::apbAddr_t coefOffset;
	logic [3:0]           coefIdx;
	logic                 isCoef;
	logic                 addrErr;
	logic                 accessPhase;
	logic                 regWrite;
	audFiltPkg::coef_t    readCoef;

	assign accessPhase = psel & penable;
	assign coefOffset  = paddr - audFiltPkg::ADDR_COEF_BASE;
	assign coefIdx     = coefOffset[5:2]; // Word index from the first coefficient
	assign readCoef    = coefMem[coefIdx];

	assign addrErr = (paddr > audFiltPkg::ADDR_POWER) || (paddr[1:0] != 2'b00);
	assign isCoef  = (paddr >= audFiltPkg::ADDR_COEF_BASE) && (paddr < audFiltPkg::ADDR_POWER)
		&& !addrErr;

	// No wait states on this slave
	assign pready  = 1'b1;
	assign pslverr = accessPhase & (addrErr | (pwrite & (paddr == audFiltPkg::ADDR_POWER)));
	assign regWrite = accessPhase & pwrite & ~pslverr;

	always_ff @(posedge aud_clk) begin
		if (reset) begin
			enable <= 1'b0;
			// Every b0 starts at unity so the channel passes samples straight through
			for (int i = 0; i < audFiltPkg::NUM_COEF; i++) begin
				coefMem[i] <= (i % audFiltPkg::COEF_PER_SECTION == 0) ?
					audFiltPkg::COEF_ONE : '0;
			end
		end else if (regWrite) begin
			if (paddr == audFiltPkg::ADDR_CTRL) begin
				enable <= pwdata[0];
			end else if (isCoef) begin
				coefMem[coefIdx] <= pwdata[26:0]; // Upper word bits are ignored
			end
		end
	end

	always_comb begin
		prdata = '0;
		if (paddr == audFiltPkg::ADDR_CTRL) begin
			prdata = {31'd0, enable};
		end else if (isCoef) begin
			prdata = {{5{readCoef[26]}}, readCoef}; // Sign extended to the bus width
		end else if (paddr == audFiltPkg::ADDR_POWER) begin
			prdata = {21'd0, power};
		end
	end

	assign s0B0 = coefMem[0];
	assign s0B1 = coefMem[1];
	assign s0B2 = coefMem[2];
	assign s0A1 = coefMem[3];
	assign s0A2 = coefMem[4];
	assign s1B0 = coefMem[5];
	assign s1B1 = coefMem[6];
	assign s1B2 = coefMem[7];
	assign s1A1 = coefMem[8];
	assign s1A2 = coefMem[9];

endmodule

/* logic/lpfChannel.sv */
module lpfChannel (
	input  logic                    aud_clk,
	input  logic                    reset,

	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  audFiltPkg::apbAddr_t    paddr,
	input  audFiltPkg::apbData_t    pwdata,
	output audFiltPkg::apbData_t    prdata,
	output logic                    pready,
	output logic                    pslverr,

	input  logic                    sampleValid,
	input  audFiltPkg::audIn_t      iAud,

	output logic                    outValid,
	output audFiltPkg::audSample_t  oAud,
	output audFiltPkg::power_t      power
);

	logic enable;
	audFiltPkg::coef_t s0B0, s0B1, s0B2, s0A1, s0A2;
	audFiltPkg::coef_t s1B0, s1B1, s1B2, s1A1, s1A2;

	logic                   stage1Valid;
	audFiltPkg::audSample_t stage1Out;
	logic                   stage2Valid;
	audFiltPkg::audSample_t stage2Out;

	coefRegs regBlock (
		.aud_clk(aud_clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.power(power), .enable(enable),
		.s0B0(s0B0), .s0B1(s0B1), .s0B2(s0B2), .s0A1(s0A1), .s0A2(s0A2),
		.s1B0(s1B0), .s1B1(s1B1), .s1B2(s1B2), .s1A1(s1A1), .s1A2(s1A2)
	);

	// Input is widened to Q4.23, the 16-bit sample lands at bits 23 down to 8
	biquadSection stage1 (
		.aud_clk(aud_clk), .reset(reset), .enable(enable),
		.inValid(sampleValid), .inSample({{3{iAud[15]}}, iAud, 8'd0}),
		.b0(s0B0), .b1(s0B1), .b2(s0B2), .a1(s0A1), .a2(s0A2),
		.outValid(stage1Valid), .outSample(stage1Out)
	);

	biquadSection stage2 (
		.aud_clk(aud_clk), .reset(reset), .enable(enable),
		.inValid(stage1Valid), .inSample(stage1Out),
		.b0(s1B0), .b1(s1B1), .b2(s1B2), .a1(s1A1), .a2(s1A2),
		.outValid(stage2Valid), .outSample(stage2Out)
	);

	powerMeter meter (
		.aud_clk(aud_clk), .reset(reset), .enable(enable),
		.inValid(stage2Valid), .inSample(stage2Out),
		.outValid(outValid), .oAud(oAud), .power(power)
	);

endmodule

/* logic/powerMeter.sv */
module powerMeter (
	input  logic                    aud_clk,
	input  logic                    reset,
	input  logic                    enable,

	input  logic                    inValid,
	input  audFiltPkg::audSample_t  inSample,

	output logic                    outValid,
	output audFiltPkg::audSample_t  oAud,
	output audFiltPkg::power_t      power
);

	audFiltPkg::powerAcc_t             powerAcc;
	audFiltPkg::powerAcc_t             accSum;
	logic [audFiltPkg::WIN_CNT_W-1:0]  winCount;
	logic [26:0]                       mag;
	logic                              windowEnd;

	// True two's complement magnitude where the most negative sample maps to 2^26
	always_comb begin
		if (inSample[26]) begin
			mag = -inSample;
		end else begin
			mag = inSample;
		end
	end

	assign accSum    = powerAcc + {13'd0, mag}; // Includes the current sample
	assign windowEnd = (winCount == audFiltPkg::WIN_CNT_W'(audFiltPkg::WINDOW_LEN - 1));

	always_ff @(posedge aud_clk) begin
		if (reset || !enable) begin
			outValid <= 1'b0;
			oAud     <= '0;
			power    <= '0;
			powerAcc <= '0;
			winCount <= '0;
		end else begin
			outValid <= inValid;
			if (inValid) begin
				oAud <= inSample;
				if (windowEnd) begin
					// Reading updates on the same edge as the last sample's outValid
					power    <= accSum[audFiltPkg::POWER_LSB +: $bits(audFiltPkg::power_t)];
					powerAcc <= '0;
					winCount <= '0;
				end else begin
					powerAcc <= accSum;
					winCount <= winCount + 1'b1;
				end
			end
		end
	end

endmodule

/* sim.f */
logic/audFiltPkg.sv
logic/coefRegs.sv
logic/biquadSection.sv
logic/powerMeter.sv
logic/lpfChannel.sv
tb/lpfChannelTb.sv

/* tb/lpfChannelTb.sv */
module lpfChannelTb;
	timeunit 1ns;
	timeprecision 1ps;

	// Two full power windows dominate the run and the other tests fit in the margin
	localparam int TIMEOUT_CYCLES = 2 * audFiltPkg::WINDOW_LEN + 5800;
	// Low-pass section with its corner near a tenth of the sample rate and a0 dropped
	localparam audFiltPkg::coef_t LP_COEF [0:4] = '{27'sd566231, 27'sd1132462, 27'sd566231,
		-27'sd9588178, 27'sd3462817};

	logic aud_clk = 1'b0;
	logic reset, psel, penable, pwrite, sampleValid;
	logic pready, pslverr, outValid;
	audFiltPkg::apbAddr_t   paddr;
	audFiltPkg::apbData_t   pwdata, prdata;
	audFiltPkg::audIn_t     iAud;
	audFiltPkg::audSample_t oAud;
	audFiltPkg::power_t     power;

	// Scoreboard model of the channel
	audFiltPkg::audSample_t expQ[$];
	audFiltPkg::power_t     powQ[$];
	int                     stampQ[$];
	audFiltPkg::coef_t      mc [0:9];
	audFiltPkg::audSample_t mx1 [0:1], mx2 [0:1], my1 [0:1], my2 [0:1];
	longint                 accModel;
	int                     winCnt;
	audFiltPkg::power_t     powerModel;
	logic                   modelEn;

	int cycleCnt = 0;
	int errCount = 0, testErrBase = 0, passTests = 0, failTests = 0;

	lpfChannel u_dut (.*);

	always #2 aud_clk = ~aud_clk;

	always @(posedge aud_clk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles without reaching the end of the tests", cycleCnt);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Each output sample is matched to the oldest expected one
	always @(negedge aud_clk) begin
		int lat;
		if (!reset && outValid) begin
			if (expQ.size() == 0) begin
				$display("ERROR @%0t: outValid raised with no sample expected", $time);
				errCount++;
			end else begin
				checkSample(oAud, expQ.pop_front(), "oAud");
				checkPower(power, powQ.pop_front(), "power at outValid");
				lat = cycleCnt - stampQ.pop_front();
				if (lat != 3) begin
					$display("ERROR @%0t: outValid %0d cycles after sampleValid, expected 3", $time, lat);
					errCount++;
				end
			end
		end
	end

	task automatic checkSample(input audFiltPkg::audSample_t got, exp, input string what);
		if (got !== exp) begin
			$display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
			errCount++;
		end
	endtask

	task automatic checkPower(input audFiltPkg::power_t got, exp, input string what);
		if (got !== exp) begin
			$display("ERROR @%0t: %s got %0d expected %0d", $time, what, got, exp);
			errCount++;
		end
	endtask

	task automatic checkApb(input audFiltPkg::apbData_t got, exp, input string what);
		if (got !== exp) begin
			$display("ERROR @%0t: read of %s got %h expected %h", $time, what, got, exp);
			errCount++;
		end
	endtask

	task automatic checkErr(input logic got, exp, input string what);
		if (got !== exp) begin
			$display("ERROR @%0t: pslverr on %s got %b expected %b", $time, what, got, exp);
			errCount++;
		end
	endtask

	task automatic apbXfer(input logic wr, input audFiltPkg::apbAddr_t addr,
		input audFiltPkg::apbData_t wdata, output audFiltPkg::apbData_t rdata, output logic err);
		@(posedge aud_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge aud_clk);
		penable <= 1'b1;
		@(negedge aud_clk);
		rdata = prdata; // Sampled mid access phase
		err   = pslverr;
		if (pready !== 1'b1) begin
			$display("ERROR @%0t: pready low in the access phase", $time);
			errCount++;
		end
		@(posedge aud_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input audFiltPkg::apbAddr_t addr, input audFiltPkg::apbData_t data,
		input logic expErr);
		audFiltPkg::apbData_t rd;
		logic err;
		apbXfer(1'b1, addr, data, rd, err);
		checkErr(err, expErr, $sformatf("write 0x%h", addr));
	endtask

	task automatic apbRead(input audFiltPkg::apbAddr_t addr, input audFiltPkg::apbData_t expData,
		input logic expErr);
		audFiltPkg::apbData_t rd;
		logic err;
		apbXfer(1'b0, addr, '0, rd, err);
		checkErr(err, expErr, $sformatf("read 0x%h", addr));
		if (!expErr) checkApb(rd, expData, $sformatf("0x%h", addr));
	endtask

	function automatic audFiltPkg::audSample_t biquadStep(input int s,
		input audFiltPkg::audSample_t x);
		longint acc;
		audFiltPkg::audSample_t y;
		acc = longint'(mc[5*s]) * longint'(x) + longint'(mc[5*s+1]) * longint'(mx1[s])
			+ longint'(mc[5*s+2]) * longint'(mx2[s]) - longint'(mc[5*s+3]) * longint'(my1[s])
			- longint'(mc[5*s+4]) * longint'(my2[s]);
		y = audFiltPkg::audSample_t'(acc >>> audFiltPkg::COEF_FRAC); // Low bits kept, so it wraps
		mx2[s] = mx1[s];
		mx1[s] = x;
		my2[s] = my1[s];
		my1[s] = y;
		return y;
	endfunction

	task automatic resetModel();
		for (int s = 0; s < 2; s++) begin
			mx1[s] = '0;
			mx2[s] = '0;
			my1[s] = '0;
			my2[s] = '0;
		end
		accModel   = 0;
		winCnt     = 0;
		powerModel = '0;
	endtask

	task automatic sendSample(input audFiltPkg::audIn_t s);
		audFiltPkg::audSample_t w, y;
		longint mag;
		@(posedge aud_clk);
		sampleValid <= 1'b1;
		iAud        <= s;
		if (modelEn) begin
			w = s;
			w = w <<< 8;
			y = biquadStep(1, biquadStep(0, w));
			mag = y;
			if (mag < 0) mag = -mag;
			accModel += mag;
			winCnt++;
			if (winCnt == audFiltPkg::WINDOW_LEN) begin
				powerModel = audFiltPkg::power_t'(accModel >> audFiltPkg::POWER_LSB);
				accModel = 0;
				winCnt = 0;
			end
			expQ.push_back(y);
			powQ.push_back(powerModel);
			stampQ.push_back(cycleCnt + 1); // The DUT sees the strobe on the next edge
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge aud_clk);
			sampleValid <= 1'b0;
		end
	endtask

	task automatic waitDrain();
		int n;
		n = 0;
		idleCycles(1);
		while (expQ.size() != 0 && n < 10) begin
			idleCycles(1);
			n++;
		end
		if (expQ.size() != 0) begin
			$display("Missing outValid: %0d expected samples never came out", expQ.size());
			errCount++;
			expQ.delete();
			powQ.delete();
			stampQ.delete();
		end
	endtask

	task automatic setCoef(input int idx, input audFiltPkg::coef_t v);
		apbWrite(audFiltPkg::ADDR_COEF_BASE + audFiltPkg::apbAddr_t'(4 * idx), {{5{v[26]}}, v}, 1'b0);
		mc[idx] = v;
	endtask

	task automatic loadCoefs(input logic lowPass);
		for (int i = 0; i < 10; i++) begin
			if (lowPass) setCoef(i, LP_COEF[i % 5]);
			else setCoef(i, (i % 5 == 0) ? audFiltPkg::COEF_ONE : '0);
		end
	endtask

	task automatic setEnable(input logic en);
		apbWrite(audFiltPkg::ADDR_CTRL, {31'd0, en}, 1'b0);
		if (!en) resetModel(); // Disabled stages rest at zero
		modelEn = en;
	endtask

	task automatic finishTest(input string name);
		if (errCount == testErrBase) begin
			passTests++;
			$display("%s: passed", name);
		end else begin
			failTests++;
			$display("%s: failed with %0d errors", name, errCount - testErrBase);
		end
		testErrBase = errCount;
	endtask

	task automatic testRegisters();
		audFiltPkg::apbData_t v;
		audFiltPkg::apbAddr_t a;
		apbRead(audFiltPkg::ADDR_CTRL, 32'd0, 1'b0);
		for (int i = 0; i < 10; i++) begin
			a = audFiltPkg::ADDR_COEF_BASE + audFiltPkg::apbAddr_t'(4 * i);
			apbRead(a, (i % 5 == 0) ? 32'h0080_0000 : 32'd0, 1'b0);
		end
		for (int i = 0; i < 10; i++) begin
			a = audFiltPkg::ADDR_COEF_BASE + audFiltPkg::apbAddr_t'(4 * i);
			v = $urandom;
			apbWrite(a, v, 1'b0);
			mc[i] = v[26:0];
		end
		// Every coefficient is written before any is read back so that aliased addresses show up
		for (int i = 0; i < 10; i++) begin
			a = audFiltPkg::ADDR_COEF_BASE + audFiltPkg::apbAddr_t'(4 * i);
			apbRead(a, {{5{mc[i][26]}}, mc[i]}, 1'b0); // Only the low 27 bits are stored
		end
		apbWrite(audFiltPkg::ADDR_CTRL, 32'd1, 1'b0);
		apbRead(audFiltPkg::ADDR_CTRL, 32'd1, 1'b0);
		apbWrite(audFiltPkg::ADDR_CTRL, 32'd0, 1'b0);
		apbRead(audFiltPkg::ADDR_CTRL, 32'd0, 1'b0);
		apbRead(8'h05, 32'd0, 1'b1);
		apbRead(8'h30, 32'd0, 1'b1);
		apbWrite(audFiltPkg::ADDR_POWER, 32'h7FF, 1'b1);
		apbRead(audFiltPkg::ADDR_POWER, 32'd0, 1'b0);
		checkPower(power, '0, "power after rejected write");
		loadCoefs(1'b0);
		finishTest("Register access");
	endtask

	task automatic testPassThrough();
		setEnable(1'b1);
		sendSample(-16'sd32768);
		sendSample(16'sd32767);
		repeat (50) sendSample(audFiltPkg::audIn_t'($urandom));
		waitDrain();
		finishTest("Pass-through latency");
	endtask

	task automatic testFilter();
		loadCoefs(1'b1);
		repeat (200) begin
			sendSample(audFiltPkg::audIn_t'($urandom));
			idleCycles($urandom % 4);
		end
		waitDrain();
		finishTest("Filter response");
	endtask

	task automatic testPowerWindow();
		loadCoefs(1'b0);
		setEnable(1'b0);
		setEnable(1'b1);
		repeat (audFiltPkg::WINDOW_LEN) sendSample(audFiltPkg::audIn_t'($urandom));
		waitDrain();
		checkPower(power, powerModel, "power after random window");
		apbRead(audFiltPkg::ADDR_POWER, {21'd0, powerModel}, 1'b0);
		// Full-scale negative input puts the window sum exactly on a reading step
		// so a magnitude short by one lowers the reading
		repeat (audFiltPkg::WINDOW_LEN) sendSample(-16'sd32768);
		waitDrain();
		checkPower(power, powerModel, "power after negative window");
		apbRead(audFiltPkg::ADDR_POWER, {21'd0, powerModel}, 1'b0);
		finishTest("Power window");
	endtask

	task automatic testRestart();
		loadCoefs(1'b1);
		fork
			repeat (24) sendSample(audFiltPkg::audIn_t'($urandom));
			begin
				repeat (10) @(posedge aud_clk);
				setEnable(1'b0);
			end
		join
		idleCycles(2);
		expQ.delete(); // Samples cut off by the disable never come out
		powQ.delete();
		stampQ.delete();
		resetModel();
		repeat (8) begin
			sendSample(audFiltPkg::audIn_t'($urandom));
			@(negedge aud_clk);
			checkPower(power, '0, "power while disabled");
		end
		waitDrain();
		apbRead(audFiltPkg::ADDR_POWER, 32'd0, 1'b0);
		setEnable(1'b1);
		sendSample(16'sd12000);
		repeat (40) sendSample(16'sd0);
		waitDrain();
		finishTest("Disable and restart");
	endtask

	initial begin
		void'($urandom(27));
		reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		sampleValid = 1'b0;
		iAud        = '0;
		modelEn     = 1'b0;
		for (int i = 0; i < 10; i++) mc[i] = (i % 5 == 0) ? audFiltPkg::COEF_ONE : '0;
		resetModel();
		repeat (3) @(posedge aud_clk);
		reset <= 1'b0;
		testRegisters();
		testPassThrough();
		testFilter();
		testPowerWindow();
		testRestart();
		$display("Summary: %0d tests passed, %0d tests failed", passTests, failTests);
		if (errCount == 0 && failTests == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
